/* verilog.f */
so_pkg.sv
so_stream_router.sv
so_buffer_engine.sv
so_write_arbiter.sv
so_axil_regs.sv
so_top.sv
so_top_assert.sv
tb_so_top.sv

/* Bender.yml */
package:
  name: so_stream_out

sources:
  - so_pkg.sv
  - so_stream_router.sv
  - so_buffer_engine.sv
  - so_write_arbiter.sv
  - so_axil_regs.sv
  - so_top.sv
  - target: test
    files:
      - so_top_assert.sv
      - tb_so_top.sv

/* tb_so_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_so_top;

  localparam int TIMEOUT = 2000;
  localparam int NUM_PRIMS = 13;
  localparam int NUM_REPLAY = 4;
  localparam logic [31:0] SEED = 32'hd023_fc7b;

  logic                                clk;
  logic                                rst_n;
  logic                                in_valid;
  logic [so_pkg::SO_BEAT_W-1:0]        in_data;
  logic                                in_last;
  logic                                in_ready;
  logic                                mem_wr_valid;
  logic [so_pkg::SO_ADDR_W-1:0]        mem_wr_addr;
  logic [so_pkg::SO_BEAT_W-1:0]        mem_wr_data;
  logic                                mem_wr_ready;
  logic                                s_axil_awvalid;
  logic                                s_axil_awready;
  logic [so_pkg::SO_AXIL_ADDR_W-1:0]   s_axil_awaddr;
  logic                                s_axil_wvalid;
  logic                                s_axil_wready;
  logic [so_pkg::SO_AXIL_DATA_W-1:0]   s_axil_wdata;
  logic [so_pkg::SO_AXIL_DATA_W/8-1:0] s_axil_wstrb;
  logic                                s_axil_bvalid;
  logic                                s_axil_bready;
  logic [1:0]                          s_axil_bresp;
  logic                                s_axil_arvalid;
  logic                                s_axil_arready;
  logic [so_pkg::SO_AXIL_ADDR_W-1:0]   s_axil_araddr;
  logic                                s_axil_rvalid;
  logic                                s_axil_rready;
  logic [so_pkg::SO_AXIL_DATA_W-1:0]   s_axil_rdata;
  logic [1:0]                          s_axil_rresp;

  int          mismatch_errs;
  int          other_errs;
  logic [31:0] data_lfsr;
  logic [31:0] ready_lfsr;

  // Reference model, expected {addr, data} per stream
  int           exp_written [so_pkg::SO_NUM_STREAMS];
  int           exp_dropped [so_pkg::SO_NUM_STREAMS];
  logic [159:0] exp_q [so_pkg::SO_NUM_STREAMS][$];

  logic [15:0] buf_sizes [so_pkg::SO_NUM_STREAMS] = '{16'd8, 16'd6, 16'd16, 16'd4};

  // Stream, header beat count, overflow expected
  logic [18:0] prim_tab [NUM_PRIMS] = '{
    {2'd0, 16'd3, 1'b0},
    {2'd1, 16'd4, 1'b0},
    {2'd2, 16'd5, 1'b0},
    {2'd3, 16'd2, 1'b0},
    {2'd0, 16'd6, 1'b1},
    {2'd0, 16'd5, 1'b0},
    {2'd1, 16'd3, 1'b1},
    {2'd1, 16'd2, 1'b0},
    {2'd3, 16'd3, 1'b1},
    {2'd3, 16'd0, 1'b0},
    {2'd2, 16'd8, 1'b0},
    {2'd2, 16'd4, 1'b1},
    {2'd2, 16'd3, 1'b0}
  };

  so_top so_top_inst (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int b = 0; b < 32; b++) begin
      data_lfsr = lfsr_step(data_lfsr);
      w = {w[30:0], data_lfsr[0]};
    end
    return w;
  endfunction

  function automatic logic [31:0] stream_base(input int s);
    return 32'h1000_0000 + s * 32'h1000;
  endfunction

  // Stream whose buffer holds the address, or -1
  function automatic int find_stream(input logic [31:0] a);
    int hit;
    hit = -1;
    for (int k = 0; k < so_pkg::SO_NUM_STREAMS; k++) begin
      if (a >= stream_base(k) && a < stream_base(k) + buf_sizes[k] * so_pkg::SO_BEAT_BYTES) begin
        hit = k;
      end
    end
    return hit;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int k = 0; k < so_pkg::SO_NUM_STREAMS; k++) begin
      n += exp_q[k].size();
    end
    return n;
  endfunction

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %0h expected %0h", name, got, exp);
      mismatch_errs++;
    end
  endtask

  task automatic end_run();
    int assert_errs;
    assert_errs = so_top_inst.so_top_assert_inst.fail_count;
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_errs, other_errs, assert_errs);
    if (mismatch_errs == 0 && other_errs == 0 && assert_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  task automatic abort_run(input string what);
    $display("Timeout: %s", what);
    other_errs++;
    end_run();
  endtask

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
    int   t;
    logic aw_done;
    logic w_done;
    @(negedge clk);
    s_axil_awaddr  = addr;
    s_axil_awvalid = 1'b1;
    s_axil_wdata   = data;
    s_axil_wvalid  = 1'b1;
    aw_done = 1'b0;
    w_done  = 1'b0;
    t = 0;
    while (!(aw_done && w_done)) begin
      @(posedge clk);
      aw_done = aw_done || (s_axil_awvalid && s_axil_awready);
      w_done  = w_done || (s_axil_wvalid && s_axil_wready);
      t++;
      if (t > TIMEOUT) abort_run("AXI write address or data was never accepted");
      @(negedge clk);
      s_axil_awvalid = s_axil_awvalid && !aw_done;
      s_axil_wvalid  = s_axil_wvalid && !w_done;
    end
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT) abort_run("AXI write response never arrived");
    end while (!s_axil_bvalid);
    check("s_axil_bresp", s_axil_bresp, 2'b00);
    // Response waits a cycle before it is taken
    @(negedge clk);
    s_axil_bready = 1'b1;
    @(negedge clk);
    s_axil_bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
    int t;
    @(negedge clk);
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT) abort_run("AXI read address was never accepted");
    end while (!s_axil_arready);
    @(negedge clk);
    s_axil_arvalid = 1'b0;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT) abort_run("AXI read data never arrived");
    end while (!s_axil_rvalid);
    data = s_axil_rdata;
    check("s_axil_rresp", s_axil_rresp, 2'b00);
    // Read data waits a cycle before it is taken
    @(negedge clk);
    s_axil_rready = 1'b1;
    @(negedge clk);
    s_axil_rready = 1'b0;
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] got;
    axil_read(addr, got);
    check(name, got, exp);
  endtask

  task automatic check_counters();
    logic [7:0] blk;
    for (int s = 0; s < so_pkg::SO_NUM_STREAMS; s++) begin
      blk = so_pkg::SO_REG_STRIDE * s;
      read_check(blk + so_pkg::SO_REG_WRITTEN, exp_written[s], $sformatf("written[%0d]", s));
      read_check(blk + so_pkg::SO_REG_DROPPED, exp_dropped[s], $sformatf("dropped[%0d]", s));
    end
  endtask

  task automatic send_beat(input logic [127:0] data, input logic last);
    int t;
    @(negedge clk);
    in_valid = 1'b1;
    in_data  = data;
    in_last  = last;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT) abort_run("input beat was never accepted");
    end while (!in_ready);
  endtask

  // One table entry: header, then its data beats with the model updated
  task automatic send_prim(input int p);
    so_pkg::so_beat_t w;
    int               s;
    int               n;
    logic             drop;
    s = prim_tab[p][18:17];
    n = (prim_tab[p][16:1] == 0) ? 1 : prim_tab[p][16:1];
    drop = (exp_written[s] + n > buf_sizes[s]);
    check($sformatf("drop_decision[%0d]", p), drop, prim_tab[p][0]);
    w = '0;
    w.attr[0] = {14'd0, prim_tab[p][16:1], prim_tab[p][18:17]};
    send_beat(w, 1'b0);
    for (int i = 0; i < n; i++) begin
      for (int k = 0; k < 4; k++) begin
        w.attr[k] = rand_word();
      end
      if (!drop) begin
        exp_q[s].push_back({stream_base(s) + (exp_written[s] + i) * 16, w.attr});
      end
      send_beat(w, i == n - 1);
    end
    if (drop) begin
      exp_dropped[s]++;
    end else begin
      exp_written[s] += n;
    end
  endtask

  task automatic drain();
    int t;
    @(negedge clk);
    in_valid = 1'b0;
    in_last  = 1'b0;
    t = 0;
    while (pending() != 0) begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT) abort_run("expected memory writes never appeared");
    end
    repeat (3) @(negedge clk);
    check("mem_wr_valid", mem_wr_valid, 1'b0);
  endtask

  // Random back-pressure on the memory port
  always @(negedge clk) begin
    ready_lfsr = lfsr_step(ready_lfsr);
    mem_wr_ready = ready_lfsr[0];
  end

  // Memory sink
  always @(posedge clk) begin
    int           s;
    logic [159:0] e;
    if (rst_n && mem_wr_valid && mem_wr_ready) begin
      s = find_stream(mem_wr_addr);
      if (s < 0 || exp_q[s].size() == 0) begin
        $display("Unexpected memory write at address %0h", mem_wr_addr);
        other_errs++;
      end else begin
        e = exp_q[s].pop_front();
        check("mem_wr_addr", mem_wr_addr, e[159:128]);
        check("mem_wr_data", mem_wr_data, e[127:0]);
      end
    end
  end

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    in_valid       = 1'b0;
    in_data        = '0;
    in_last        = 1'b0;
    mem_wr_ready   = 1'b0;
    s_axil_awvalid = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '1;
    s_axil_bready  = 1'b0;
    s_axil_arvalid = 1'b0;
    s_axil_araddr  = '0;
    s_axil_rready  = 1'b0;
    mismatch_errs  = 0;
    other_errs     = 0;
    data_lfsr      = SEED;
    ready_lfsr     = SEED;
    for (int s = 0; s < so_pkg::SO_NUM_STREAMS; s++) begin
      exp_written[s] = 0;
      exp_dropped[s] = 0;
    end
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // Disabled after reset, a pending header must not be taken
    in_valid = 1'b1;
    in_data  = 128'h1_0004;
    repeat (5) begin
      @(negedge clk);
      check("in_ready", in_ready, 1'b0);
      check("mem_wr_valid", mem_wr_valid, 1'b0);
    end
    in_valid = 1'b0;
    check_counters();

    for (int s = 0; s < so_pkg::SO_NUM_STREAMS; s++) begin
      axil_write(so_pkg::SO_REG_STRIDE * s + so_pkg::SO_REG_BASE, stream_base(s));
      axil_write(so_pkg::SO_REG_STRIDE * s + so_pkg::SO_REG_SIZE, buf_sizes[s]);
    end
    for (int s = 0; s < so_pkg::SO_NUM_STREAMS; s++) begin
      read_check(so_pkg::SO_REG_STRIDE * s + so_pkg::SO_REG_BASE, stream_base(s),
                 $sformatf("buf_base[%0d]", s));
      read_check(so_pkg::SO_REG_STRIDE * s + so_pkg::SO_REG_SIZE, buf_sizes[s],
                 $sformatf("buf_size[%0d]", s));
    end

    axil_write(so_pkg::SO_REG_CTRL, 32'h1);
    for (int p = 0; p < NUM_PRIMS; p++) begin
      send_prim(p);
    end
    drain();
    check_counters();

    // Clear with enable kept on, then the buffers refill from their bases
    axil_write(so_pkg::SO_REG_CTRL, 32'h3);
    for (int s = 0; s < so_pkg::SO_NUM_STREAMS; s++) begin
      exp_written[s] = 0;
      exp_dropped[s] = 0;
    end
    // Clear reads back as zero, enable stays set
    read_check(so_pkg::SO_REG_CTRL, 32'h1, "ctrl");
    check_counters();
    for (int p = 0; p < NUM_REPLAY; p++) begin
      send_prim(p);
    end
    drain();
    check_counters();
    end_run();
  end

endmodule

`default_nettype wire

/* so_top_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module so_top_assert (
  input wire                          clk,
  input wire                          rst_n,
  input wire                          mem_wr_valid,
  input wire                          mem_wr_ready,
  input wire [so_pkg::SO_ADDR_W-1:0]  mem_wr_addr,
  input wire [so_pkg::SO_BEAT_W-1:0]  mem_wr_data,
  input wire                          s_axil_bvalid,
  input wire                          s_axil_bready,
  input wire                          s_axil_rvalid,
  input wire                          s_axil_rready
);

  // Failed assertions so far
  int fail_count = 0;

  // Stalled memory write keeps its address and data
  a_mem_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_wr_valid && !mem_wr_ready |=>
      mem_wr_valid && $stable(mem_wr_addr) && $stable(mem_wr_data))
    else begin
      $error("memory write changed while stalled");
      fail_count++;
    end

  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
    else begin
      $error("write response dropped before bready");
      fail_count++;
    end

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
    else begin
      $error("read data dropped before rready");
      fail_count++;
    end

endmodule

bind so_top so_top_assert so_top_assert_inst (
  .clk           (clk),
  .rst_n         (rst_n),
  .mem_wr_valid  (mem_wr_valid),
  .mem_wr_ready  (mem_wr_ready),
  .mem_wr_addr   (mem_wr_addr),
  .mem_wr_data   (mem_wr_data),
  .s_axil_bvalid (s_axil_bvalid),
  .s_axil_bready (s_axil_bready),
  .s_axil_rvalid (s_axil_rvalid),
  .s_axil_rready (s_axil_rready)
);

`default_nettype wire

/* so_top.sv */
`timescale 1ns/10ps
`default_nettype none

module so_top (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  in_valid,
  input  wire  [so_pkg::SO_BEAT_W-1:0]         in_data,
  input  wire                                  in_last,
  output logic                                 in_ready,
  output logic                                 mem_wr_valid,
  output logic [so_pkg::SO_ADDR_W-1:0]         mem_wr_addr,
  output logic [so_pkg::SO_BEAT_W-1:0]         mem_wr_data,
  input  wire                                  mem_wr_ready,
  input  wire                                  s_axil_awvalid,
  output logic                                 s_axil_awready,
  input  wire  [so_pkg::SO_AXIL_ADDR_W-1:0]    s_axil_awaddr,
  input  wire                                  s_axil_wvalid,
  output logic                                 s_axil_wready,
  input  wire  [so_pkg::SO_AXIL_DATA_W-1:0]    s_axil_wdata,
  input  wire  [so_pkg::SO_AXIL_DATA_W/8-1:0]  s_axil_wstrb,
  output logic                                 s_axil_bvalid,
  input  wire                                  s_axil_bready,
  output logic [1:0]                           s_axil_bresp,
  input  wire                                  s_axil_arvalid,
  output logic                                 s_axil_arready,
  input  wire  [so_pkg::SO_AXIL_ADDR_W-1:0]    s_axil_araddr,
  output logic                                 s_axil_rvalid,
  input  wire                                  s_axil_rready,
  output logic [so_pkg::SO_AXIL_DATA_W-1:0]    s_axil_rdata,
  output logic [1:0]                           s_axil_rresp
);

  logic [so_pkg::SO_NUM_STREAMS-1:0][so_pkg::SO_ADDR_W-1:0] buf_base;
  logic [so_pkg::SO_NUM_STREAMS-1:0][so_pkg::SO_CNT_W-1:0]  buf_size;
  logic [so_pkg::SO_NUM_STREAMS-1:0][so_pkg::SO_CNT_W-1:0]  written;
  logic [so_pkg::SO_NUM_STREAMS-1:0][so_pkg::SO_CNT_W-1:0]  dropped;
  logic                                                     enable;
  logic                                                     clear;

  logic [so_pkg::SO_NUM_STREAMS-1:0]   prim_valid;
  logic [so_pkg::SO_NUM_STREAMS-1:0]   prim_ready;
  so_pkg::so_beat_t                    prim_data;
  logic                                prim_first;
  logic [so_pkg::SO_CNT_W-1:0]         prim_beats;

  logic [so_pkg::SO_NUM_STREAMS-1:0]                        req_valid;
  logic [so_pkg::SO_NUM_STREAMS-1:0]                        req_ready;
  logic [so_pkg::SO_NUM_STREAMS-1:0][so_pkg::SO_ADDR_W-1:0] req_addr;
  logic [so_pkg::SO_NUM_STREAMS-1:0][so_pkg::SO_BEAT_W-1:0] req_data;

  so_axil_regs regs_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .buf_base       (buf_base),
    .buf_size       (buf_size),
    .enable         (enable),
    .clear          (clear),
    .written        (written),
    .dropped        (dropped)
  );

  so_stream_router router_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_last    (in_last),
    .in_ready   (in_ready),
    .enable     (enable),
    .prim_valid (prim_valid),
    .prim_data  (prim_data),
    .prim_first (prim_first),
    .prim_beats (prim_beats),
    .prim_ready (prim_ready)
  );

  // One engine per output buffer
  for (genvar i = 0; i < so_pkg::SO_NUM_STREAMS; i++) begin : g_engine
    so_buffer_engine engine_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .prim_valid (prim_valid[i]),
      .prim_data  (prim_data),
      .prim_first (prim_first),
      .prim_beats (prim_beats),
      .prim_ready (prim_ready[i]),
      .buf_base   (buf_base[i]),
      .buf_size   (buf_size[i]),
      .clear      (clear),
      .req_valid  (req_valid[i]),
      .req_addr   (req_addr[i]),
      .req_data   (req_data[i]),
      .req_ready  (req_ready[i]),
      .written    (written[i]),
      .dropped    (dropped[i])
    );
  end

  so_write_arbiter arbiter_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid    (req_valid),
    .req_addr     (req_addr),
    .req_data     (req_data),
    .req_ready    (req_ready),
    .mem_wr_valid (mem_wr_valid),
    .mem_wr_addr  (mem_wr_addr),
    .mem_wr_data  (mem_wr_data),
    .mem_wr_ready (mem_wr_ready)
  );

endmodule

`default_nettype wire

/* so_axil_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module so_axil_regs (
  input  wire                                                    clk,
  input  wire                                                    rst_n,
  input  wire                                                    s_axil_awvalid,
  output logic                                                   s_axil_awready,
  input  wire  [so_pkg::SO_AXIL_ADDR_W-1:0]                      s_axil_awaddr,
  input  wire                                                    s_axil_wvalid,
  output logic                                                   s_axil_wready,
  input  wire  [so_pkg::SO_AXIL_DATA_W-1:0]                      s_axil_wdata,
  input  wire  [so_pkg::SO_AXIL_DATA_W/8-1:0]                    s_axil_wstrb,
  output logic                                                   s_axil_bvalid,
  input  wire                                                    s_axil_bready,
  output logic [1:0]                                             s_axil_bresp,
  input  wire                                                    s_axil_arvalid,
  output logic                                                   s_axil_arready,
  input  wire  [so_pkg::SO_AXIL_ADDR_W-1:0]                      s_axil_araddr,
  output logic                                                   s_axil_rvalid,
  input  wire                                                    s_axil_rready,
  output logic [so_pkg::SO_AXIL_DATA_W-1:0]                      s_axil_rdata,
  output logic [1:0]                                             s_axil_rresp,
  output logic [so_pkg::SO_NUM_STREAMS-1:0][so_pkg::SO_ADDR_W-1:0] buf_base,
  output logic [so_pkg::SO_NUM_STREAMS-1:0][so_pkg::SO_CNT_W-1:0]  buf_size,
  output logic                                                   enable,
  output logic                                                   clear,
  input  wire  [so_pkg::SO_NUM_STREAMS-1:0][so_pkg::SO_CNT_W-1:0]  written,
  input  wire  [so_pkg::SO_NUM_STREAMS-1:0][so_pkg::SO_CNT_W-1:0]  dropped
);

  logic                              aw_held;
  logic                              w_held;
  logic [so_pkg::SO_AXIL_ADDR_W-1:0] awaddr_q;
  logic [so_pkg::SO_AXIL_DATA_W-1:0] wdata_q;
  logic                              aw_fire;
  logic                              w_fire;
  logic                              ar_fire;
  logic                              do_wr;
  logic [so_pkg::SO_AXIL_ADDR_W-1:0] wr_addr;
  logic [so_pkg::SO_AXIL_DATA_W-1:0] wr_data;
  logic [7:0]                        wr_slot;
  logic [7:0]                        rd_slot;
  logic [7:0]                        wr_off;
  logic [7:0]                        rd_off;
  logic [so_pkg::SO_AXIL_DATA_W-1:0] rd_word;

  // Registers take whole words, strobes are not decoded
  assign s_axil_awready = !aw_held && !s_axil_bvalid;
  assign s_axil_wready  = !w_held && !s_axil_bvalid;
  assign s_axil_arready = !s_axil_rvalid;
  assign s_axil_bresp   = 2'b00;
  assign s_axil_rresp   = 2'b00;

  assign aw_fire = s_axil_awvalid && s_axil_awready;
  assign w_fire  = s_axil_wvalid && s_axil_wready;
  assign ar_fire = s_axil_arvalid && s_axil_arready;

  // Write goes ahead once both halves are in, in either order
  assign do_wr   = (aw_held || aw_fire) && (w_held || w_fire);
  assign wr_addr = aw_held ? awaddr_q : s_axil_awaddr;
  assign wr_data = w_held ? wdata_q : s_axil_wdata;

  // Stream index and offset within its block
  assign wr_slot = wr_addr / so_pkg::SO_REG_STRIDE;
  assign wr_off  = wr_addr % so_pkg::SO_REG_STRIDE;
  assign rd_slot = s_axil_araddr / so_pkg::SO_REG_STRIDE;
  assign rd_off  = s_axil_araddr % so_pkg::SO_REG_STRIDE;

  always_comb begin
    rd_word = '0;
    if (s_axil_araddr < so_pkg::SO_REG_CTRL) begin
      case (rd_off)
        so_pkg::SO_REG_BASE:    rd_word = buf_base[rd_slot[so_pkg::SO_STREAM_W-1:0]];
        so_pkg::SO_REG_SIZE:
          rd_word[so_pkg::SO_CNT_W-1:0] = buf_size[rd_slot[so_pkg::SO_STREAM_W-1:0]];
        so_pkg::SO_REG_WRITTEN:
          rd_word[so_pkg::SO_CNT_W-1:0] = written[rd_slot[so_pkg::SO_STREAM_W-1:0]];
        so_pkg::SO_REG_DROPPED:
          rd_word[so_pkg::SO_CNT_W-1:0] = dropped[rd_slot[so_pkg::SO_STREAM_W-1:0]];
        default:                rd_word = '0;
      endcase
    end else if (s_axil_araddr == so_pkg::SO_REG_CTRL) begin
      rd_word[0] = enable;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_held       <= 1'b0;
      w_held        <= 1'b0;
      s_axil_bvalid <= 1'b0;
      s_axil_rvalid <= 1'b0;
      buf_base      <= '0;
      buf_size      <= '0;
      enable        <= 1'b0;
      clear         <= 1'b0;
    end else begin
      clear <= 1'b0;
      if (s_axil_bvalid && s_axil_bready) begin
        s_axil_bvalid <= 1'b0;
      end
      if (do_wr) begin
        aw_held       <= 1'b0;
        w_held        <= 1'b0;
        s_axil_bvalid <= 1'b1;
        if (wr_addr < so_pkg::SO_REG_CTRL) begin
          if (wr_off == so_pkg::SO_REG_BASE) begin
            buf_base[wr_slot[so_pkg::SO_STREAM_W-1:0]] <= wr_data;
          end
          if (wr_off == so_pkg::SO_REG_SIZE) begin
            buf_size[wr_slot[so_pkg::SO_STREAM_W-1:0]] <= wr_data[so_pkg::SO_CNT_W-1:0];
          end
        end else if (wr_addr == so_pkg::SO_REG_CTRL) begin
          enable <= wr_data[0];
          clear  <= wr_data[1];
        end
      end else begin
        if (aw_fire) aw_held <= 1'b1;
        if (w_fire)  w_held  <= 1'b1;
      end
      if (ar_fire) begin
        s_axil_rvalid <= 1'b1;
      end else if (s_axil_rready) begin
        s_axil_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) awaddr_q <= s_axil_awaddr;
    if (w_fire)  wdata_q  <= s_axil_wdata;
    if (ar_fire) s_axil_rdata <= rd_word;
  end

endmodule

`default_nettype wire

/* so_write_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module so_write_arbiter (
  input  wire                                                    clk,
  input  wire                                                    rst_n,
  input  wire  [so_pkg::SO_NUM_STREAMS-1:0]                      req_valid,
  input  wire  [so_pkg::SO_NUM_STREAMS-1:0][so_pkg::SO_ADDR_W-1:0] req_addr,
  input  wire  [so_pkg::SO_NUM_STREAMS-1:0][so_pkg::SO_BEAT_W-1:0] req_data,
  output logic [so_pkg::SO_NUM_STREAMS-1:0]                      req_ready,
  output logic                                                   mem_wr_valid,
  output logic [so_pkg::SO_ADDR_W-1:0]                           mem_wr_addr,
  output logic [so_pkg::SO_BEAT_W-1:0]                           mem_wr_data,
  input  wire                                                    mem_wr_ready
);

  logic [so_pkg::SO_STREAM_W-1:0] last_q;
  logic [so_pkg::SO_STREAM_W-1:0] held_q;
  logic                           locked_q;
  logic [so_pkg::SO_STREAM_W-1:0] cand;
  logic [so_pkg::SO_STREAM_W-1:0] pick;
  logic [so_pkg::SO_STREAM_W-1:0] gnt;
  logic                           found;

  // Search starts one past the last served requester
  always_comb begin
    pick  = last_q;
    found = 1'b0;
    cand  = last_q;
    for (int k = 1; k <= so_pkg::SO_NUM_STREAMS; k++) begin
      cand = last_q + k[so_pkg::SO_STREAM_W-1:0];
      if (!found && req_valid[cand]) begin
        pick  = cand;
        found = 1'b1;
      end
    end
  end

  // Stalled output keeps its grant
  assign gnt          = locked_q ? held_q : pick;
  assign mem_wr_valid = req_valid[gnt];
  assign mem_wr_addr  = req_addr[gnt];
  assign mem_wr_data  = req_data[gnt];

  always_comb begin
    req_ready      = '0;
    req_ready[gnt] = mem_wr_ready;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_q   <= '1;
      held_q   <= '0;
      locked_q <= 1'b0;
    end else if (mem_wr_valid) begin
      if (mem_wr_ready) begin
        last_q   <= gnt;
        locked_q <= 1'b0;
      end else begin
        held_q   <= gnt;
        locked_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* so_buffer_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module so_buffer_engine (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             prim_valid,
  input  wire so_pkg::so_beat_t           prim_data,
  input  wire                             prim_first,
  input  wire  [so_pkg::SO_CNT_W-1:0]     prim_beats,
  output logic                            prim_ready,
  input  wire  [so_pkg::SO_ADDR_W-1:0]    buf_base,
  input  wire  [so_pkg::SO_CNT_W-1:0]     buf_size,
  input  wire                             clear,
  output logic                            req_valid,
  output logic [so_pkg::SO_ADDR_W-1:0]    req_addr,
  output logic [so_pkg::SO_BEAT_W-1:0]    req_data,
  input  wire                             req_ready,
  output logic [so_pkg::SO_CNT_W-1:0]     written,
  output logic [so_pkg::SO_CNT_W-1:0]     dropped
);

  logic [so_pkg::SO_ADDR_W-1:0] addr_mem [so_pkg::SO_FIFO_DEPTH];
  so_pkg::so_beat_t             data_mem [so_pkg::SO_FIFO_DEPTH];

  logic [$clog2(so_pkg::SO_FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(so_pkg::SO_FIFO_DEPTH)-1:0] rd_ptr;
  logic [$clog2(so_pkg::SO_FIFO_DEPTH):0]   count;

  logic                         keep_q;
  logic [so_pkg::SO_CNT_W-1:0]  idx_q;
  logic [so_pkg::SO_CNT_W:0]    need;
  logic                         fits;
  logic                         keep;
  logic                         push;
  logic                         pop;
  logic [so_pkg::SO_CNT_W-1:0]  beat_idx;
  logic [so_pkg::SO_ADDR_W-1:0] beat_off;

  // Reservation check, one bit wider so the sum cannot wrap
  assign need = {1'b0, written} + {1'b0, prim_beats};
  assign fits = (need <= {1'b0, buf_size});

  // Keep-or-drop is decided on the first beat and held after it
  assign keep       = prim_first ? fits : keep_q;
  assign prim_ready = keep ? (count != so_pkg::SO_FIFO_DEPTH) : 1'b1;
  assign push       = prim_valid && prim_ready && keep;
  assign pop        = req_valid && req_ready;

  // First beat lands right after what the stream already holds
  assign beat_idx = prim_first ? written : idx_q;
  assign beat_off = beat_idx * so_pkg::SO_BEAT_BYTES;

  assign req_valid = (count != '0);
  assign req_addr  = addr_mem[rd_ptr];
  assign req_data  = data_mem[rd_ptr].attr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      keep_q  <= 1'b0;
      idx_q   <= '0;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      written <= '0;
      dropped <= '0;
    end else begin
      if (prim_valid && prim_ready) begin
        if (prim_first) begin
          keep_q <= fits;
        end
        if (keep) begin
          idx_q <= beat_idx + 1'b1;
        end
      end
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (!push && pop) begin
        count <= count - 1'b1;
      end
      if (clear) begin
        written <= '0;
        dropped <= '0;
      end else if (prim_valid && prim_first) begin
        if (!fits) begin
          dropped <= dropped + 1'b1;
        end else if (prim_ready) begin
          // Whole primitive is counted at admission
          written <= need[so_pkg::SO_CNT_W-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      addr_mem[wr_ptr] <= buf_base + beat_off;
      data_mem[wr_ptr] <= prim_data;
    end
  end

endmodule

`default_nettype wire

/* so_stream_router.sv */
`timescale 1ns/10ps
`default_nettype none

module so_stream_router (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  in_valid,
  input  wire  [so_pkg::SO_BEAT_W-1:0]         in_data,
  input  wire                                  in_last,
  output logic                                 in_ready,
  input  wire                                  enable,
  output logic [so_pkg::SO_NUM_STREAMS-1:0]    prim_valid,
  output so_pkg::so_beat_t                     prim_data,
  output logic                                 prim_first,
  output logic [so_pkg::SO_CNT_W-1:0]          prim_beats,
  input  wire  [so_pkg::SO_NUM_STREAMS-1:0]    prim_ready
);

  so_pkg::so_beat_t              word;
  logic                          data_st;
  logic                          first_q;
  logic [so_pkg::SO_STREAM_W-1:0] sel_q;
  logic [so_pkg::SO_CNT_W-1:0]   beats_q;

  assign word = in_data;

  // Headers are swallowed here, data beats wait on the chosen engine
  assign in_ready = enable && (!data_st || prim_ready[sel_q]);

  always_comb begin
    prim_valid        = '0;
    prim_valid[sel_q] = in_valid && enable && data_st;
  end

  assign prim_data  = word;
  assign prim_first = first_q;
  assign prim_beats = beats_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_st <= 1'b0;
      first_q <= 1'b0;
      sel_q   <= '0;
      beats_q <= '0;
    end else if (in_valid && in_ready) begin
      if (!data_st) begin
        data_st <= 1'b1;
        first_q <= 1'b1;
        sel_q   <= word.hdr.stream;
        // A zero count still carries one data beat
        beats_q <= (word.hdr.beats == '0) ? so_pkg::SO_CNT_W'(1) : word.hdr.beats;
      end else begin
        first_q <= 1'b0;
        if (in_last) begin
          data_st <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* so_pkg.sv */
`default_nettype none

package so_pkg;

  localparam int SO_NUM_STREAMS = 4;
  localparam int SO_STREAM_W    = 2;
  localparam int SO_ADDR_W      = 32;
  localparam int SO_BEAT_W      = 128;
  localparam int SO_BEAT_BYTES  = 16;
  localparam int SO_FIFO_DEPTH  = 8;
  localparam int SO_CNT_W       = 16;

  localparam int SO_AXIL_ADDR_W = 8;
  localparam int SO_AXIL_DATA_W = 32;

  // Register map, one block of four words per stream
  localparam logic [7:0] SO_REG_STRIDE  = 8'd16;
  localparam logic [7:0] SO_REG_BASE    = 8'd0;
  localparam logic [7:0] SO_REG_SIZE    = 8'd4;
  localparam logic [7:0] SO_REG_WRITTEN = 8'd8;
  localparam logic [7:0] SO_REG_DROPPED = 8'd12;
  localparam logic [7:0] SO_REG_CTRL    = 8'h40;

  // One beat, seen as a primitive header or as four attributes
  typedef union packed {
    struct packed {
      logic [SO_BEAT_W-SO_CNT_W-SO_STREAM_W-1:0] rsvd;
      logic [SO_CNT_W-1:0]                       beats;
      logic [SO_STREAM_W-1:0]                    stream;
    } hdr;
    logic [3:0][31:0] attr;
  } so_beat_t;

endpackage

`default_nettype wire
